//--- hw/radio_pkg.sv
/*
   Shared types and register maps for the daughterboard radio slots.
   Settings and readback addresses are 8 bit and absolute per slot.
   Samples carry I in the upper half and Q in the lower half.
*/
package radio_pkg;

   // --------------------
   // widths with a meaning
   // --------------------
   typedef logic [31:0] sample_t;   // {i, q}
   typedef logic [15:0] iq_t;       // one signed half of a sample
   typedef logic [31:0] gpio_t;     // gpio, ddr or misc word
   typedef logic [7:0]  sr_addr_t;
   typedef logic [31:0] sr_data_t;
   typedef logic [63:0] rb_data_t;
   typedef logic [2:0]  led_t;      // {RX, TXRX_TX, TXRX_RX}

   // settings write, single cycle strobe
   typedef struct packed {
      logic     stb;
      sr_addr_t addr;
      sr_data_t data;
   } set_bus_t;

   // readback request, answered one cycle later
   typedef struct packed {
      logic     stb;
      sr_addr_t addr;
   } rb_req_t;

   // decoded tx/rx level, bit 0 = rx, bit 1 = tx
   typedef enum logic [1:0] {
      ATR_IDLE = 2'd0,
      ATR_RX   = 2'd1,
      ATR_TX   = 2'd2,
      ATR_FDX  = 2'd3
   } atr_state_e;

   // front-end correction, low three bits of the written word
   typedef struct packed {
      logic swap_iq;
      logic invert_i;
      logic invert_q;
   } fe_cfg_t;

   // --------------------
   // settings map
   // --------------------
   localparam sr_addr_t SR_DB_BASE        = 8'd160;
   localparam sr_addr_t SR_MISC_OUT       = 8'd0;   // offsets from SR_DB_BASE
   localparam sr_addr_t SR_GPIO_DDR       = 8'd1;
   localparam sr_addr_t SR_ATR_IDLE       = 8'd2;   // idle, rx, tx, fdx are consecutive
   localparam sr_addr_t SR_ATR_RX         = 8'd3;
   localparam sr_addr_t SR_ATR_TX         = 8'd4;
   localparam sr_addr_t SR_ATR_FDX        = 8'd5;
   localparam sr_addr_t SR_TX_FE_BASE     = 8'd208;
   localparam sr_addr_t SR_RX_FE_BASE     = 8'd224;
   localparam sr_addr_t SR_FE_CHAN_OFFSET = 8'd16;  // step between rx channels

   // --------------------
   // readback map
   // --------------------
   localparam sr_addr_t RB_DB_BASE  = 8'd16;
   localparam sr_addr_t RB_GPIO_IN  = 8'd0;   // {misc_in, gpio_in}
   localparam sr_addr_t RB_GPIO_OUT = 8'd1;   // {gpio_ddr, gpio_out}

   // full scale limits of one half
   localparam iq_t IQ_MIN = 16'h8000;
   localparam iq_t IQ_MAX = 16'h7fff;

endpackage

//--- hw/db_gpio_atr.sv
`timescale 1ns/100ps
/*
   GPIO output selected by the registered tx/rx state, one word per state.
   Output and LEDs lag the run flags and ATR writes by two cycles.
   Direction register drives the pins directly, one cycle after its write.
*/
module db_gpio_atr (
   input  logic                  radio_clk,
   input  logic                  i_reset,
   input  radio_pkg::set_bus_t   i_set,
   input  radio_pkg::atr_state_e i_atr,
   output radio_pkg::gpio_t      o_gpio_out,
   output radio_pkg::gpio_t      o_gpio_ddr,
   output radio_pkg::led_t       o_leds
);

   localparam radio_pkg::sr_addr_t ADDR_DDR  = radio_pkg::SR_DB_BASE + radio_pkg::SR_GPIO_DDR;
   localparam radio_pkg::sr_addr_t ADDR_ATR0 = radio_pkg::SR_DB_BASE + radio_pkg::SR_ATR_IDLE;

   radio_pkg::gpio_t      atr_regs [4];   // indexed by atr_state_e
   radio_pkg::atr_state_e atr_r;
   radio_pkg::sr_addr_t   atr_off;
   radio_pkg::led_t       led_next;

   assign atr_off = i_set.addr - ADDR_ATR0;   // wraps high below the block

   // --------------------
   // register writes
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         for (int k = 0; k < 4; k++) begin
            atr_regs[k] <= '0;
         end
         o_gpio_ddr <= '0;
      end else if (i_set.stb) begin
         if (atr_off < 8'd4) begin
            atr_regs[atr_off[1:0]] <= i_set.data;   // idle/rx/tx/fdx in enum order
         end
         if (i_set.addr == ADDR_DDR) begin
            o_gpio_ddr <= i_set.data;
         end
      end
   end

   // fdx lights the rx antenna, tx/rx antenna shows tx or rx-only
   assign led_next = {atr_r == radio_pkg::ATR_FDX,
                      (atr_r == radio_pkg::ATR_TX) || (atr_r == radio_pkg::ATR_FDX),
                      atr_r == radio_pkg::ATR_RX};

   // --------------------
   // state and output stage
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         atr_r      <= radio_pkg::ATR_IDLE;
         o_gpio_out <= '0;
         o_leds     <= '0;
      end else begin
         atr_r      <= i_atr;             // stage 1, level from run flags
         o_gpio_out <= atr_regs[atr_r];   // stage 2
         o_leds     <= led_next;
      end
   end

endmodule

//--- hw/db_control.sv
`timescale 1ns/100ps
/*
   Per-slot daughterboard control: misc output register, ATR GPIO and readback.
   Only the daughterboard block of the settings map is decoded here.
   Readback answers one cycle after the request, unmapped addresses read zero.
   Misc in/out pin registers live in the slot, outside this block.
*/
module db_control (
   input  logic                  radio_clk,
   input  logic                  i_reset,
   input  radio_pkg::set_bus_t   i_set,
   input  radio_pkg::rb_req_t    i_rb,
   input  radio_pkg::atr_state_e i_atr,
   input  radio_pkg::gpio_t      i_gpio_in,
   input  radio_pkg::gpio_t      i_misc_in,
   output radio_pkg::gpio_t      o_gpio_out,
   output radio_pkg::gpio_t      o_gpio_ddr,
   output radio_pkg::led_t       o_leds,
   output radio_pkg::gpio_t      o_misc_out,
   output radio_pkg::rb_data_t   o_rb_data,
   output logic                  o_rb_stb
);

   localparam radio_pkg::sr_addr_t ADDR_MISC =
      radio_pkg::SR_DB_BASE + radio_pkg::SR_MISC_OUT;
   localparam radio_pkg::sr_addr_t ADDR_RB_IN =
      radio_pkg::RB_DB_BASE + radio_pkg::RB_GPIO_IN;
   localparam radio_pkg::sr_addr_t ADDR_RB_OUT =
      radio_pkg::RB_DB_BASE + radio_pkg::RB_GPIO_OUT;

   radio_pkg::rb_data_t rb_word;

   // --------------------
   // gpio with atr select
   // --------------------
   db_gpio_atr u_gpio_atr (
      .radio_clk  (radio_clk),
      .i_reset    (i_reset),
      .i_set      (i_set),
      .i_atr      (i_atr),
      .o_gpio_out (o_gpio_out),
      .o_gpio_ddr (o_gpio_ddr),
      .o_leds     (o_leds)
   );

   // misc output word, pin register follows in the slot
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_misc_out <= '0;
      end else if (i_set.stb && (i_set.addr == ADDR_MISC)) begin
         o_misc_out <= i_set.data;
      end
   end

   // --------------------
   // readback
   // --------------------
   always_comb begin
      case (i_rb.addr)
         ADDR_RB_IN:  rb_word = {i_misc_in, i_gpio_in};
         ADDR_RB_OUT: rb_word = {o_gpio_ddr, o_gpio_out};   // current pin drive
         default:     rb_word = '0;
      endcase
   end

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_rb_stb  <= 1'b0;
         o_rb_data <= '0;
      end else begin
         o_rb_stb <= i_rb.stb;   // exactly one cycle later
         if (i_rb.stb) begin
            o_rb_data <= rb_word;   // held until the next request
         end
      end
   end

endmodule

//--- hw/fe_control.sv
`timescale 1ns/100ps
/*
   Front-end IQ swap and inversion, per rx channel plus one tx channel.
   Swap is applied first, then the selected halves are negated.
   Negating -32768 saturates to 32767. Output is registered, one cycle latency.
*/
module fe_control #(
   parameter int NUM_CHANNELS = 2
) (
   input  logic                radio_clk,
   input  logic                i_reset,
   input  radio_pkg::set_bus_t i_set,
   input  radio_pkg::sample_t  i_rx [NUM_CHANNELS],
   input  radio_pkg::sample_t  i_tx_data,
   output radio_pkg::sample_t  o_rx_data [NUM_CHANNELS],
   output radio_pkg::sample_t  o_tx
);

   radio_pkg::fe_cfg_t rx_cfg [NUM_CHANNELS];
   radio_pkg::fe_cfg_t tx_cfg;

   // two's complement negate, clamped at full scale
   function automatic radio_pkg::iq_t neg_sat(input radio_pkg::iq_t x);
      return (x == radio_pkg::IQ_MIN) ? radio_pkg::IQ_MAX : radio_pkg::iq_t'(-x);
   endfunction

   function automatic radio_pkg::sample_t fix_sample(input radio_pkg::sample_t s,
                                                     input radio_pkg::fe_cfg_t c);
      radio_pkg::iq_t i_part;
      radio_pkg::iq_t q_part;
      i_part = c.swap_iq ? s[15:0] : s[31:16];
      q_part = c.swap_iq ? s[31:16] : s[15:0];
      if (c.invert_i) begin
         i_part = neg_sat(i_part);
      end
      if (c.invert_q) begin
         q_part = neg_sat(q_part);
      end
      return {i_part, q_part};
   endfunction

   // --------------------
   // rx channels
   // --------------------
   for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_rx
      localparam radio_pkg::sr_addr_t ADDR_CFG =
         radio_pkg::SR_RX_FE_BASE + ch * radio_pkg::SR_FE_CHAN_OFFSET;

      always_ff @(posedge radio_clk) begin
         if (i_reset) begin
            rx_cfg[ch] <= '0;
         end else if (i_set.stb && (i_set.addr == ADDR_CFG)) begin
            rx_cfg[ch] <= radio_pkg::fe_cfg_t'(i_set.data[2:0]);
         end
      end

      always_ff @(posedge radio_clk) begin
         if (i_reset) begin
            o_rx_data[ch] <= '0;
         end else begin
            o_rx_data[ch] <= fix_sample(i_rx[ch], rx_cfg[ch]);   // rx valid every cycle
         end
      end
   end

   // --------------------
   // tx channel to dac
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         tx_cfg <= '0;
         o_tx   <= '0;
      end else begin
         if (i_set.stb && (i_set.addr == radio_pkg::SR_TX_FE_BASE)) begin
            tx_cfg <= radio_pkg::fe_cfg_t'(i_set.data[2:0]);
         end
         o_tx <= fix_sample(i_tx_data, tx_cfg);
      end
   end

endmodule

//--- hw/radio_slot.sv
`timescale 1ns/100ps
/*
   One daughterboard slot: db control and front end on a shared settings bus.
   Run flags of all channels are ORed, so GPIOs cannot tell channels apart.
   Every rx channel sees the same ADC word. Misc pins are registered here.
*/
module radio_slot #(
   parameter int NUM_CHANNELS = 2
) (
   input  logic                    radio_clk,
   input  logic                    i_reset,
   input  radio_pkg::set_bus_t     i_set,
   input  radio_pkg::rb_req_t      i_rb,
   input  logic [NUM_CHANNELS-1:0] i_run_rx,
   input  logic [NUM_CHANNELS-1:0] i_run_tx,
   input  radio_pkg::sample_t      i_rx,
   input  radio_pkg::sample_t      i_tx_data,
   input  radio_pkg::gpio_t        i_db_gpio_in,
   input  radio_pkg::gpio_t        i_misc_in,
   output radio_pkg::sample_t      o_rx_data [NUM_CHANNELS],
   output radio_pkg::sample_t      o_tx,
   output radio_pkg::gpio_t        o_db_gpio_out,
   output radio_pkg::gpio_t        o_db_gpio_ddr,
   output radio_pkg::led_t         o_leds,
   output radio_pkg::gpio_t        o_misc_out,
   output radio_pkg::rb_data_t     o_rb_data,
   output logic                    o_rb_stb
);

   radio_pkg::atr_state_e atr;
   radio_pkg::gpio_t      misc_in_r;    // pin side
   radio_pkg::gpio_t      misc_out_w;   // register side
   radio_pkg::sample_t    rx_dup [NUM_CHANNELS];

   // any channel running counts, bit 0 rx and bit 1 tx
   assign atr = radio_pkg::atr_state_e'({|i_run_tx, |i_run_rx});

   for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_dup
      assign rx_dup[ch] = i_rx;   // one adc, all channels
   end

   // --------------------
   // misc pin registers
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         misc_in_r  <= '0;
         o_misc_out <= '0;
      end else begin
         misc_in_r  <= i_misc_in;
         o_misc_out <= misc_out_w;
      end
   end

   db_control u_db_control (
      .radio_clk  (radio_clk),
      .i_reset    (i_reset),
      .i_set      (i_set),
      .i_rb       (i_rb),
      .i_atr      (atr),
      .i_gpio_in  (i_db_gpio_in),
      .i_misc_in  (misc_in_r),
      .o_gpio_out (o_db_gpio_out),
      .o_gpio_ddr (o_db_gpio_ddr),
      .o_leds     (o_leds),
      .o_misc_out (misc_out_w),
      .o_rb_data  (o_rb_data),
      .o_rb_stb   (o_rb_stb)
   );

   fe_control #(
      .NUM_CHANNELS (NUM_CHANNELS)
   ) u_fe_control (
      .radio_clk (radio_clk),
      .i_reset   (i_reset),
      .i_set     (i_set),
      .i_rx      (rx_dup),
      .i_tx_data (i_tx_data),
      .o_rx_data (o_rx_data),
      .o_tx      (o_tx)
   );

endmodule

//--- hw/radio_core.sv
`timescale 1ns/100ps
/*
   Radio clock domain top: one slot per daughterboard.
   All ports are unpacked per slot, rx data also per channel.
*/
module radio_core #(
   parameter int NUM_SLOTS             = 2,
   parameter int NUM_CHANNELS_PER_SLOT = 2
) (
   input  logic                             radio_clk,
   input  logic                             i_reset,
   input  radio_pkg::set_bus_t              i_set         [NUM_SLOTS],
   input  radio_pkg::rb_req_t               i_rb          [NUM_SLOTS],
   input  logic [NUM_CHANNELS_PER_SLOT-1:0] i_run_rx      [NUM_SLOTS],
   input  logic [NUM_CHANNELS_PER_SLOT-1:0] i_run_tx      [NUM_SLOTS],
   input  radio_pkg::sample_t               i_rx          [NUM_SLOTS],
   input  radio_pkg::sample_t               i_tx_data     [NUM_SLOTS],
   input  radio_pkg::gpio_t                 i_db_gpio_in  [NUM_SLOTS],
   input  radio_pkg::gpio_t                 i_misc_in     [NUM_SLOTS],
   output radio_pkg::sample_t               o_rx_data     [NUM_SLOTS][NUM_CHANNELS_PER_SLOT],
   output radio_pkg::sample_t               o_tx          [NUM_SLOTS],
   output radio_pkg::gpio_t                 o_db_gpio_out [NUM_SLOTS],
   output radio_pkg::gpio_t                 o_db_gpio_ddr [NUM_SLOTS],
   output radio_pkg::led_t                  o_leds        [NUM_SLOTS],
   output radio_pkg::gpio_t                 o_misc_out    [NUM_SLOTS],
   output radio_pkg::rb_data_t              o_rb_data     [NUM_SLOTS],
   output logic                             o_rb_stb      [NUM_SLOTS]
);

   // --------------------
   // slots
   // --------------------
   for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slot
      radio_slot #(
         .NUM_CHANNELS (NUM_CHANNELS_PER_SLOT)
      ) u_slot (
         .radio_clk     (radio_clk),
         .i_reset       (i_reset),
         .i_set         (i_set[s]),
         .i_rb          (i_rb[s]),
         .i_run_rx      (i_run_rx[s]),
         .i_run_tx      (i_run_tx[s]),
         .i_rx          (i_rx[s]),
         .i_tx_data     (i_tx_data[s]),
         .i_db_gpio_in  (i_db_gpio_in[s]),
         .i_misc_in     (i_misc_in[s]),
         .o_rx_data     (o_rx_data[s]),
         .o_tx          (o_tx[s]),
         .o_db_gpio_out (o_db_gpio_out[s]),
         .o_db_gpio_ddr (o_db_gpio_ddr[s]),
         .o_leds        (o_leds[s]),
         .o_misc_out    (o_misc_out[s]),
         .o_rb_data     (o_rb_data[s]),
         .o_rb_stb      (o_rb_stb[s])
      );
   end

endmodule

//--- verif/radio_model.svh
/*
   Reference functions for the slot behaviour, included into the testbench.
   ATR words are passed in enum order: idle, rx, tx, fdx.
*/
`ifndef RADIO_MODEL_SVH
`define RADIO_MODEL_SVH

// negate one half, -32768 clamps to 32767
function automatic radio_pkg::iq_t negate_clamped(input radio_pkg::iq_t x);
   int v;
   v = -int'($signed(x));
   if (v > 32767) v = 32767;   // only -32768 overflows
   return radio_pkg::iq_t'(v);
endfunction

// swap first, then invert
function automatic radio_pkg::sample_t corrected_sample(input radio_pkg::sample_t s,
                                                        input radio_pkg::fe_cfg_t c);
   radio_pkg::iq_t hi;
   radio_pkg::iq_t lo;
   hi = s[31:16];
   lo = s[15:0];
   if (c.swap_iq) begin
      hi = s[15:0];
      lo = s[31:16];
   end
   if (c.invert_i) hi = negate_clamped(hi);
   if (c.invert_q) lo = negate_clamped(lo);
   return {hi, lo};
endfunction

// ored run flags to state
function automatic radio_pkg::atr_state_e ored_state(input logic any_rx, input logic any_tx);
   if (any_rx && any_tx) return radio_pkg::ATR_FDX;
   if (any_tx) return radio_pkg::ATR_TX;
   if (any_rx) return radio_pkg::ATR_RX;
   return radio_pkg::ATR_IDLE;
endfunction

function automatic radio_pkg::gpio_t selected_gpio(input radio_pkg::gpio_t atr_regs [4],
                                                   input radio_pkg::atr_state_e st);
   return atr_regs[st];
endfunction

// {RX, TXRX_TX, TXRX_RX}
function automatic radio_pkg::led_t led_pattern(input radio_pkg::atr_state_e st);
   case (st)
      radio_pkg::ATR_RX:  return 3'b001;
      radio_pkg::ATR_TX:  return 3'b010;
      radio_pkg::ATR_FDX: return 3'b110;   // rx led plus tx/rx on tx
      default:            return 3'b000;
   endcase
endfunction

// readback word for an absolute address, zero when unmapped
function automatic radio_pkg::rb_data_t readback_word(input radio_pkg::sr_addr_t addr,
   input radio_pkg::gpio_t gpio_in, input radio_pkg::gpio_t misc_in,
   input radio_pkg::gpio_t gpio_out, input radio_pkg::gpio_t gpio_ddr);
   if (addr == radio_pkg::RB_DB_BASE + radio_pkg::RB_GPIO_IN) return {misc_in, gpio_in};
   if (addr == radio_pkg::RB_DB_BASE + radio_pkg::RB_GPIO_OUT) return {gpio_ddr, gpio_out};
   return '0;
endfunction

`endif

//--- verif/radio_core_tb.sv
`timescale 1ns/100ps
/*
   Testbench for radio_core with two slots of two channels each.
   Inputs change on the falling edge; outputs are checked on a later falling edge.
   Expected values come from the model functions and mirrored registers.
*/
module radio_core_tb;

   localparam int NS         = 2;   // slots
   localparam int NC         = 2;   // channels per slot
   localparam int RB_TIMEOUT = 8;   // cycles to wait for the readback strobe

   logic                radio_clk = 1'b0;
   logic                i_reset;
   radio_pkg::set_bus_t i_set        [NS];
   radio_pkg::rb_req_t  i_rb         [NS];
   logic [NC-1:0]       i_run_rx     [NS];
   logic [NC-1:0]       i_run_tx     [NS];
   radio_pkg::sample_t  i_rx         [NS];
   radio_pkg::sample_t  i_tx_data    [NS];
   radio_pkg::gpio_t    i_db_gpio_in [NS];
   radio_pkg::gpio_t    i_misc_in    [NS];
   radio_pkg::sample_t  o_rx_data    [NS][NC];
   radio_pkg::sample_t  o_tx         [NS];
   radio_pkg::gpio_t    o_db_gpio_out [NS];
   radio_pkg::gpio_t    o_db_gpio_ddr [NS];
   radio_pkg::led_t     o_leds       [NS];
   radio_pkg::gpio_t    o_misc_out   [NS];
   radio_pkg::rb_data_t o_rb_data    [NS];
   logic                o_rb_stb     [NS];

   integer seed         = 77974;
   int     errors       = 0;
   int     checks       = 0;
   int     tests        = 0;
   int     failed_tests = 0;
   int     err_mark;

   // mirrored slot registers
   radio_pkg::fe_cfg_t rx_cfg_m [NS][NC];
   radio_pkg::fe_cfg_t tx_cfg_m [NS];
   radio_pkg::gpio_t   atr_m    [NS][4];   // idle, rx, tx, fdx
   radio_pkg::gpio_t   ddr_m    [NS];
   radio_pkg::gpio_t   misc_m   [NS];

`include "radio_model.svh"

   always #2 radio_clk = ~radio_clk;   // 4 ns period

   radio_core #(
      .NUM_SLOTS             (NS),
      .NUM_CHANNELS_PER_SLOT (NC)
   ) i_radio_core (
      .radio_clk     (radio_clk),
      .i_reset       (i_reset),
      .i_set         (i_set),
      .i_rb          (i_rb),
      .i_run_rx      (i_run_rx),
      .i_run_tx      (i_run_tx),
      .i_rx          (i_rx),
      .i_tx_data     (i_tx_data),
      .i_db_gpio_in  (i_db_gpio_in),
      .i_misc_in     (i_misc_in),
      .o_rx_data     (o_rx_data),
      .o_tx          (o_tx),
      .o_db_gpio_out (o_db_gpio_out),
      .o_db_gpio_ddr (o_db_gpio_ddr),
      .o_leds        (o_leds),
      .o_misc_out    (o_misc_out),
      .o_rb_data     (o_rb_data),
      .o_rb_stb      (o_rb_stb)
   );

   // --------------------
   // compare tasks
   // --------------------
   task automatic check_sample(input string name, input radio_pkg::sample_t exp,
                               input radio_pkg::sample_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_gpio(input string name, input radio_pkg::gpio_t exp,
                             input radio_pkg::gpio_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_leds(input string name, input radio_pkg::led_t exp,
                             input radio_pkg::led_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_rb(input string name, input radio_pkg::rb_data_t exp,
                           input radio_pkg::rb_data_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   // --------------------
   // stimulus helpers
   // --------------------
   function automatic logic [31:0] rand32();
      return $random(seed);
   endfunction

   // random sample, often with a -32768 half to hit the clamp
   function automatic radio_pkg::sample_t rand_sample();
      logic [31:0] r;
      r = rand32();
      if (r[3:0] == 4'd0) r[31:16] = radio_pkg::IQ_MIN;
      if (r[7:4] == 4'd0) r[15:0] = radio_pkg::IQ_MIN;
      return r;
   endfunction

   // one cycle strobe on the settings bus
   task automatic write_reg(input int s, input radio_pkg::sr_addr_t addr,
                            input radio_pkg::sr_data_t data);
      @(negedge radio_clk);
      i_set[s] = {1'b1, addr, data};
      @(negedge radio_clk);
      i_set[s].stb = 1'b0;
   endtask

   // request, then wait for the strobe with a timeout
   task automatic read_back(input int s, input radio_pkg::sr_addr_t addr,
                            input radio_pkg::rb_data_t exp);
      int cnt;
      @(negedge radio_clk);
      i_rb[s] = {1'b1, addr};
      cnt = 0;
      do begin
         @(negedge radio_clk);
         i_rb[s].stb = 1'b0;
         cnt++;
      end while (!o_rb_stb[s] && cnt < RB_TIMEOUT);
      if (!o_rb_stb[s]) begin
         errors++;
         $display("no readback strobe from slot %0d within %0d cycles", s, RB_TIMEOUT);
      end else if (cnt != 1) begin
         errors++;
         $display("readback strobe of slot %0d came after %0d cycles, not 1", s, cnt);
      end else begin
         check_rb($sformatf("o_rb_data[%0d] addr %h", s, addr), exp, o_rb_data[s]);
         @(negedge radio_clk);
         if (o_rb_stb[s]) begin
            errors++;
            $display("readback strobe of slot %0d held longer than one cycle", s);
         end
      end
   endtask

   task automatic finish_test(input string name);
      tests++;
      if (errors == err_mark) begin
         $display("test %-16s ok", name);
      end else begin
         failed_tests++;
         $display("test %-16s FAIL, %0d errors", name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   // --------------------
   // tests
   // --------------------
   task automatic reset_outputs();
      for (int s = 0; s < NS; s++) begin
         for (int ch = 0; ch < NC; ch++) begin
            check_sample($sformatf("o_rx_data[%0d][%0d]", s, ch), '0, o_rx_data[s][ch]);
         end
         check_sample($sformatf("o_tx[%0d]", s), '0, o_tx[s]);
         check_gpio($sformatf("o_db_gpio_out[%0d]", s), '0, o_db_gpio_out[s]);
         check_gpio($sformatf("o_db_gpio_ddr[%0d]", s), '0, o_db_gpio_ddr[s]);
         check_gpio($sformatf("o_misc_out[%0d]", s), '0, o_misc_out[s]);
         check_leds($sformatf("o_leds[%0d]", s), '0, o_leds[s]);
         if (o_rb_stb[s] !== 1'b0) begin
            errors++;
            $display("readback strobe of slot %0d not low after reset", s);
         end
      end
   endtask

   // rx and tx outputs against last cycle's inputs
   task automatic stream_samples(input int n);
      radio_pkg::sample_t rx_prev [NS];
      radio_pkg::sample_t tx_prev [NS];
      for (int k = 0; k <= n; k++) begin
         @(negedge radio_clk);
         for (int s = 0; s < NS; s++) begin
            if (k > 0) begin
               for (int ch = 0; ch < NC; ch++) begin
                  check_sample($sformatf("o_rx_data[%0d][%0d]", s, ch),
                               corrected_sample(rx_prev[s], rx_cfg_m[s][ch]),
                               o_rx_data[s][ch]);
               end
               check_sample($sformatf("o_tx[%0d]", s),
                            corrected_sample(tx_prev[s], tx_cfg_m[s]), o_tx[s]);
            end
            rx_prev[s]   = rand_sample();
            tx_prev[s]   = rand_sample();
            i_rx[s]      = rx_prev[s];
            i_tx_data[s] = tx_prev[s];
         end
      end
   endtask

   task automatic rx_correction();
      for (int s = 0; s < NS; s++) begin
         for (int ch = 0; ch < NC; ch++) begin
            rx_cfg_m[s][ch] = radio_pkg::fe_cfg_t'(rand32() & 32'h7);
            write_reg(s, radio_pkg::SR_RX_FE_BASE + ch * radio_pkg::SR_FE_CHAN_OFFSET,
                      32'(rx_cfg_m[s][ch]));
         end
      end
      stream_samples(200);
   endtask

   task automatic tx_correction();
      for (int s = 0; s < NS; s++) begin
         tx_cfg_m[s] = radio_pkg::fe_cfg_t'(rand32() & 32'h7);
         write_reg(s, radio_pkg::SR_TX_FE_BASE, 32'(tx_cfg_m[s]));
      end
      stream_samples(200);
   endtask

   // gpio and leds lag the run flags by two cycles
   task automatic atr_outputs();
      radio_pkg::atr_state_e hist1 [NS];
      radio_pkg::atr_state_e hist2 [NS];
      radio_pkg::gpio_t      regs [4];
      logic [31:0]           r;
      for (int s = 0; s < NS; s++) begin
         for (int a = 0; a < 4; a++) begin
            atr_m[s][a] = rand32();
            write_reg(s, radio_pkg::SR_DB_BASE + radio_pkg::SR_ATR_IDLE + a, atr_m[s][a]);
         end
         ddr_m[s] = rand32();
         write_reg(s, radio_pkg::SR_DB_BASE + radio_pkg::SR_GPIO_DDR, ddr_m[s]);
         hist1[s] = radio_pkg::ATR_IDLE;   // flags idle during the writes
         hist2[s] = radio_pkg::ATR_IDLE;
      end
      for (int k = 0; k < 300; k++) begin
         @(negedge radio_clk);
         for (int s = 0; s < NS; s++) begin
            regs = atr_m[s];
            check_gpio($sformatf("o_db_gpio_out[%0d]", s), selected_gpio(regs, hist2[s]),
                       o_db_gpio_out[s]);
            check_leds($sformatf("o_leds[%0d]", s), led_pattern(hist2[s]), o_leds[s]);
            check_gpio($sformatf("o_db_gpio_ddr[%0d]", s), ddr_m[s], o_db_gpio_ddr[s]);
            r = rand32();
            i_run_rx[s] = r[NC-1:0];
            i_run_tx[s] = r[NC+7:8];
            hist2[s] = hist1[s];
            hist1[s] = ored_state(|i_run_rx[s], |i_run_tx[s]);
         end
      end
   endtask

   task automatic misc_and_readback();
      radio_pkg::gpio_t old_misc;
      for (int s = 0; s < NS; s++) begin
         old_misc  = misc_m[s];
         misc_m[s] = rand32();
         write_reg(s, radio_pkg::SR_DB_BASE + radio_pkg::SR_MISC_OUT, misc_m[s]);
         check_gpio($sformatf("o_misc_out[%0d]", s), old_misc, o_misc_out[s]);  // pin reg pending
         @(negedge radio_clk);
         check_gpio($sformatf("o_misc_out[%0d]", s), misc_m[s], o_misc_out[s]);
      end
      @(negedge radio_clk);
      for (int s = 0; s < NS; s++) begin
         i_run_rx[s]     = '0;   // back to idle, gpio_out shows the idle word
         i_run_tx[s]     = '0;
         i_db_gpio_in[s] = rand32();
         i_misc_in[s]    = rand32();
      end
      repeat (3) @(negedge radio_clk);
      for (int s = 0; s < NS; s++) begin
         read_back(s, radio_pkg::RB_DB_BASE + radio_pkg::RB_GPIO_IN,
                   readback_word(radio_pkg::RB_DB_BASE + radio_pkg::RB_GPIO_IN,
                                 i_db_gpio_in[s], i_misc_in[s], atr_m[s][0], ddr_m[s]));
         read_back(s, radio_pkg::RB_DB_BASE + radio_pkg::RB_GPIO_OUT,
                   readback_word(radio_pkg::RB_DB_BASE + radio_pkg::RB_GPIO_OUT,
                                 i_db_gpio_in[s], i_misc_in[s], atr_m[s][0], ddr_m[s]));
         read_back(s, radio_pkg::RB_DB_BASE + 8'd2, '0);   // unmapped
      end
   endtask

   // --------------------
   // sequence
   // --------------------
   initial begin
      i_reset = 1'b1;
      for (int s = 0; s < NS; s++) begin
         i_set[s]        = '0;
         i_rb[s]         = '0;
         i_run_rx[s]     = '0;
         i_run_tx[s]     = '0;
         i_rx[s]         = '0;
         i_tx_data[s]    = '0;
         i_db_gpio_in[s] = '0;
         i_misc_in[s]    = '0;
         tx_cfg_m[s]     = '0;
         misc_m[s]       = '0;
         ddr_m[s]        = '0;
         for (int ch = 0; ch < NC; ch++) begin
            rx_cfg_m[s][ch] = '0;
         end
      end
      err_mark = 0;
      repeat (10) @(posedge radio_clk);
      @(negedge radio_clk);
      i_reset = 1'b0;
      @(negedge radio_clk);
      reset_outputs();
      finish_test("reset");
      rx_correction();
      finish_test("rx correction");
      tx_correction();
      finish_test("tx correction");
      atr_outputs();
      finish_test("atr gpio leds");
      misc_and_readback();
      finish_test("misc readback");
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests, failed_tests, checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // whole run bound
   initial begin
      #20000;
      $display("simulation stopped by watchdog after 20000 ns");
      $display("Test failed");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+verif
hw/radio_pkg.sv
hw/db_gpio_atr.sv
hw/db_control.sv
hw/fe_control.sv
hw/radio_slot.sv
hw/radio_core.sv
verif/radio_core_tb.sv

//--- Bender.yml
package:
  name: radio_core

sources:
  - hw/radio_pkg.sv
  - hw/db_gpio_atr.sv
  - hw/db_control.sv
  - hw/fe_control.sv
  - hw/radio_slot.sv
  - hw/radio_core.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/radio_core_tb.sv
